// File: hw/mat_add_pkg.sv
`default_nettype none

package mat_add_pkg;

    localparam int ELEM_WIDTH = 9;
    localparam int MAX_DIM    = 5;
    localparam int MAX_ELEMS  = MAX_DIM * MAX_DIM;
    localparam int DIM_WIDTH  = 3;

    typedef logic [ELEM_WIDTH-1:0] elem_t;
    typedef logic [DIM_WIDTH-1:0]  dim_t;

    // one grid row, indexed by column
    typedef elem_t [MAX_DIM-1:0] grid_row_t;
    typedef grid_row_t [MAX_DIM-1:0] grid_t;

    // elements compact in row-major order
    typedef struct packed {
        dim_t                  rows;
        dim_t                  cols;
        elem_t [MAX_ELEMS-1:0] elems;
    } matrix_t;

    typedef struct packed {
        matrix_t a;
        matrix_t b;
    } mat_req_t;

    // all zero when valid is clear
    typedef struct packed {
        logic                  valid;
        dim_t                  rows;
        dim_t                  cols;
        elem_t [MAX_ELEMS-1:0] elems;
    } mat_res_t;

    typedef struct packed {
        logic      valid;
        logic      first;
        logic      last;
        logic      reject;
        dim_t      row;
        dim_t      cols;
        grid_row_t a_row;
        grid_row_t b_row;
        dim_t      rows;
    } row_beat_t;

    typedef struct packed {
        logic  valid;
        logic  first;
        logic  last;
        logic  reject;
        dim_t  row;
        dim_t  rows;
        dim_t  cols;
        elem_t sum;
    } lane_out_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_DONE,
        HOLD_ACK
    } feeder_state_t;

endpackage

`default_nettype wire

// File: hw/row_feeder.sv
`default_nettype none

module row_feeder import mat_add_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      req,
    input  mat_req_t  request,
    input  logic      done,
    output logic      ack,
    output row_beat_t beat
);

    feeder_state_t state;
    dim_t          row_cnt;
    dim_t          rows_q;
    dim_t          cols_q;
    logic          reject_q;
    grid_t         a_grid;
    grid_t         b_grid;
    logic          dims_ok;
    logic          last_row;
    logic          accept;

    // compact operand onto the 5x5 grid, zero outside the matrix
    function automatic grid_t spread(matrix_t m);
        grid_t g;
        int    idx;
        g = '0;
        for (int i = 0; i < MAX_DIM; i++) begin
            for (int j = 0; j < MAX_DIM; j++) begin
                idx = i * int'(m.cols) + j;
                if (i < int'(m.rows) && j < int'(m.cols) && idx < MAX_ELEMS) begin
                    g[i][j] = m.elems[idx];
                end
            end
        end
        return g;
    endfunction

    // both shapes equal and inside 1..5
    always_comb begin
        dims_ok = (request.a.rows == request.b.rows) &&
                  (request.a.cols == request.b.cols) &&
                  (request.a.rows != '0) &&
                  (request.a.cols != '0) &&
                  (request.a.rows <= dim_t'(MAX_DIM)) &&
                  (request.a.cols <= dim_t'(MAX_DIM));
    end

    assign accept   = (state == IDLE) && req;
    // a rejected request goes out as one beat
    assign last_row = reject_q || (row_cnt == rows_q - dim_t'(1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= IDLE;
            row_cnt  <= '0;
            rows_q   <= '0;
            cols_q   <= '0;
            reject_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        row_cnt  <= '0;
                        reject_q <= !dims_ok;
                        rows_q   <= dims_ok ? request.a.rows : '0;
                        cols_q   <= dims_ok ? request.a.cols : '0;
                        state    <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (last_row) begin
                        state <= WAIT_DONE;
                    end else begin
                        row_cnt <= row_cnt + dim_t'(1);
                    end
                end
                WAIT_DONE: begin
                    if (done) begin
                        state <= HOLD_ACK;
                    end
                end
                HOLD_ACK: begin
                    // four-phase return to zero
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_grid <= spread(request.a);
            b_grid <= spread(request.b);
        end
    end

    always_comb begin
        beat.valid  = (state == ISSUE);
        beat.first  = (row_cnt == '0);
        beat.last   = last_row;
        beat.reject = reject_q;
        beat.row    = row_cnt;
        beat.cols   = cols_q;
        beat.a_row  = a_grid[row_cnt];
        beat.b_row  = b_grid[row_cnt];
        beat.rows   = rows_q;
    end

    assign ack = (state == HOLD_ACK);

endmodule

`default_nettype wire

// File: hw/column_lane.sv
`default_nettype none

module column_lane import mat_add_pkg::*; #(
    parameter int LANE = 0
) (
    input  logic      clk,
    input  logic      reset_n,
    input  row_beat_t beat,
    output lane_out_t lane_out
);

    logic  in_matrix;
    elem_t sum_next;

    assign in_matrix = (LANE < int'(beat.cols)) && !beat.reject;

    // wraps modulo 512, carry dropped
    assign sum_next = in_matrix ? elem_t'(beat.a_row[LANE] + beat.b_row[LANE]) : '0;

    // one stage, control travels with the sum
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane_out <= '0;
        end else begin
            lane_out.valid  <= beat.valid;
            lane_out.first  <= beat.first;
            lane_out.last   <= beat.last;
            lane_out.reject <= beat.reject;
            lane_out.row    <= beat.row;
            lane_out.rows   <= beat.rows;
            lane_out.cols   <= beat.cols;
            lane_out.sum    <= sum_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/result_collector.sv
`default_nettype none

module result_collector import mat_add_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  lane_out_t [MAX_DIM-1:0] lanes,
    output mat_res_t                result,
    output logic                    done
);

    lane_out_t ctl;
    grid_row_t row_sums;
    grid_t     grid;
    logic      pending;
    dim_t      rows_q;
    dim_t      cols_q;
    logic      reject_q;

    // lanes run in lockstep, lane 0 carries the control
    assign ctl = lanes[0];

    always_comb begin
        for (int j = 0; j < MAX_DIM; j++) begin
            row_sums[j] = lanes[j].sum;
        end
    end

    // grid (i, j) goes to compact index i * cols + j
    function automatic mat_res_t pack(grid_t g, dim_t rows, dim_t cols);
        mat_res_t r;
        int       idx;
        r       = '0;
        r.valid = 1'b1;
        r.rows  = rows;
        r.cols  = cols;
        for (int i = 0; i < MAX_DIM; i++) begin
            for (int j = 0; j < MAX_DIM; j++) begin
                idx = i * int'(cols) + j;
                if (i < int'(rows) && j < int'(cols) && idx < MAX_ELEMS) begin
                    r.elems[idx] = g[i][j];
                end
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (ctl.valid) begin
            // new matrix starts from a clean grid
            if (ctl.first) begin
                grid <= '0;
            end
            grid[ctl.row] <= row_sums;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending  <= 1'b0;
            done     <= 1'b0;
            rows_q   <= '0;
            cols_q   <= '0;
            reject_q <= 1'b0;
            result   <= '0;
        end else begin
            done <= 1'b0;
            if (ctl.valid && ctl.last) begin
                pending  <= 1'b1;
                rows_q   <= ctl.rows;
                cols_q   <= ctl.cols;
                reject_q <= ctl.reject;
            end
            // last row is in the grid by now
            if (pending) begin
                pending <= 1'b0;
                done    <= 1'b1;
                result  <= reject_q ? mat_res_t'('0) : pack(grid, rows_q, cols_q);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/matrix_adder.sv
`default_nettype none

module matrix_adder import mat_add_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     req,
    input  mat_req_t request,
    output logic     ack,
    output mat_res_t result
);

    row_beat_t               beat;
    lane_out_t [MAX_DIM-1:0] lane_outs;
    logic                    done;

    row_feeder row_feeder_i (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (req),
        .request (request),
        .done    (done),
        .ack     (ack),
        .beat    (beat)
    );

    // one adder per grid column
    for (genvar i = 0; i < MAX_DIM; i++) begin : g_lane
        column_lane #(
            .LANE (i)
        ) column_lane_i (
            .clk      (clk),
            .reset_n  (reset_n),
            .beat     (beat),
            .lane_out (lane_outs[i])
        );
    end

    result_collector result_collector_i (
        .clk     (clk),
        .reset_n (reset_n),
        .lanes   (lane_outs),
        .result  (result),
        .done    (done)
    );

endmodule

`default_nettype wire

// File: tb/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

localparam int MAX_CASES = 16;

// one table row: operand shapes, fill mode, extra hold of req
typedef struct packed {
    dim_t a_rows;
    dim_t a_cols;
    dim_t b_rows;
    dim_t b_cols;
    logic fill_max;
    logic hold;
} case_t;

string       case_names [MAX_CASES];
case_t       cases [MAX_CASES];
int          num_cases;
logic [31:0] lcg_state;

task automatic add_case(
    input string name,
    input int    a_rows,
    input int    a_cols,
    input int    b_rows,
    input int    b_cols,
    input logic  fill_max,
    input logic  hold
);
    case_names[num_cases]      = name;
    cases[num_cases].a_rows    = a_rows[DIM_WIDTH-1:0];
    cases[num_cases].a_cols    = a_cols[DIM_WIDTH-1:0];
    cases[num_cases].b_rows    = b_rows[DIM_WIDTH-1:0];
    cases[num_cases].b_cols    = b_cols[DIM_WIDTH-1:0];
    cases[num_cases].fill_max  = fill_max;
    cases[num_cases].hold      = hold;
    num_cases++;
endtask

task automatic load_cases();
    num_cases = 0;
    add_case("rand_5x5", 5, 5, 5, 5, 1'b0, 1'b1);
    add_case("rand_2x3", 2, 3, 2, 3, 1'b0, 1'b0);
    add_case("rand_1x5", 1, 5, 1, 5, 1'b0, 1'b0);
    add_case("rand_4x1", 4, 1, 4, 1, 1'b0, 1'b0);
    add_case("mismatch_3x3_3x4", 3, 3, 3, 4, 1'b0, 1'b0);
    add_case("zero_rows_0x2", 0, 2, 0, 2, 1'b0, 1'b0);
    add_case("oversize_6x6", 6, 6, 6, 6, 1'b0, 1'b0);
    add_case("max_5x5", 5, 5, 5, 5, 1'b1, 1'b1);
    add_case("max_2x3", 2, 3, 2, 3, 1'b1, 1'b0);
    add_case("rand_3x3", 3, 3, 3, 3, 1'b0, 1'b0);
endtask

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// all 25 slots filled, so stale data past rows*cols must not leak through
function automatic mat_req_t build_request(input int c);
    mat_req_t    r;
    logic [31:0] rnd;
    r        = '0;
    r.a.rows = cases[c].a_rows;
    r.a.cols = cases[c].a_cols;
    r.b.rows = cases[c].b_rows;
    r.b.cols = cases[c].b_cols;
    for (int k = 0; k < MAX_ELEMS; k++) begin
        if (cases[c].fill_max) begin
            r.a.elems[k] = '1;
            r.b.elems[k] = '1;
        end else begin
            rnd          = lcg_next();
            r.a.elems[k] = rnd[24:16];
            rnd          = lcg_next();
            r.b.elems[k] = rnd[24:16];
        end
    end
    return r;
endfunction

// both operands compact with equal cols, so sums pair up by index
function automatic mat_res_t expected_result(input mat_req_t r);
    mat_res_t e;
    int       count;
    int       sum;
    logic     shape_ok;
    e        = '0;
    shape_ok = (r.a.rows == r.b.rows) && (r.a.cols == r.b.cols) &&
               (r.a.rows >= 1) && (r.a.rows <= MAX_DIM) &&
               (r.a.cols >= 1) && (r.a.cols <= MAX_DIM);
    if (shape_ok) begin
        e.valid = 1'b1;
        e.rows  = r.a.rows;
        e.cols  = r.a.cols;
        count   = int'(r.a.rows) * int'(r.a.cols);
        for (int k = 0; k < count; k++) begin
            sum        = (int'(r.a.elems[k]) + int'(r.b.elems[k])) % 512;
            e.elems[k] = sum[ELEM_WIDTH-1:0];
        end
    end
    return e;
endfunction

`endif

// File: tb/tb_matrix_adder.sv
`default_nettype none

module tb_matrix_adder import mat_add_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_TIMEOUT = 50;
    localparam int HOLD_CYCLES = 20;

    logic     clk;
    logic     reset_n;
    logic     req;
    mat_req_t request;
    logic     ack;
    mat_res_t result;

    int       errors;
    int       timeouts;
    logic     aborted;
    // result due to hold since the last rise of ack
    mat_res_t held;

    `include "tb_cases.svh"

    matrix_adder matrix_adder_i (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (req),
        .request (request),
        .ack     (ack),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(
        input string       name,
        input string       field,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %0d, actual %0d", name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic check_result(input string name, input mat_res_t exp, input mat_res_t act);
        check_value(name, "valid", exp.valid, act.valid);
        check_value(name, "rows", exp.rows, act.rows);
        check_value(name, "cols", exp.cols, act.cols);
        for (int k = 0; k < MAX_ELEMS; k++) begin
            check_value(name, $sformatf("elem[%0d]", k), exp.elems[k], act.elems[k]);
        end
    endtask

    // outputs sampled on the falling edge
    task automatic wait_for_ack(input logic level, input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ack !== level && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== level) begin
            $display("Timeout: ack did not go to %0b in case %s within %0d cycles",
                     level, name, ACK_TIMEOUT);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_case(input int c);
        mat_req_t r;
        mat_res_t exp;
        string    name;
        name = case_names[c];
        r    = build_request(c);
        exp  = expected_result(r);
        if (result !== held) begin
            $display("FAILED %s previous result: expected %h, actual %h", name, held, result);
            errors++;
        end
        @(posedge clk);
        request <= r;
        req     <= 1'b1;
        wait_for_ack(1'b1, name);
        if (aborted) begin
            return;
        end
        check_result(name, exp, result);
        held = exp;
        if (cases[c].hold) begin
            for (int i = 0; i < HOLD_CYCLES; i++) begin
                @(negedge clk);
                if (ack !== 1'b1) begin
                    $display("ack dropped while req was still high in case %s", name);
                    errors++;
                end
            end
        end
        @(posedge clk);
        req <= 1'b0;
        wait_for_ack(1'b0, name);
        if (aborted) begin
            return;
        end
        if (result !== held) begin
            $display("FAILED %s held result: expected %h, actual %h", name, held, result);
            errors++;
        end
    endtask

    initial begin
        reset_n   = 1'b0;
        req       = 1'b0;
        request   = '0;
        errors    = 0;
        timeouts  = 0;
        aborted   = 1'b0;
        held      = '0;
        lcg_state = 32'd67684;
        load_cases();
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("ack is not low after reset");
            errors++;
        end
        if (result !== held) begin
            $display("FAILED reset result: expected %h, actual %h", held, result);
            errors++;
        end
        // cases run back to back
        for (int c = 0; c < num_cases; c++) begin
            if (!aborted) begin
                run_case(c);
            end
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+tb
hw/mat_add_pkg.sv
hw/row_feeder.sv
hw/column_lane.sv
hw/result_collector.sv
hw/matrix_adder.sv
tb/tb_matrix_adder.sv

// File: Bender.yml
package:
  name: matrix_adder

sources:
  - files:
      - hw/mat_add_pkg.sv
      - hw/row_feeder.sv
      - hw/column_lane.sv
      - hw/result_collector.sv
      - hw/matrix_adder.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_matrix_adder.sv
